// ==== design/lsu_params.svh ====
// Sizing and address map for the load/store unit.
// Included by the package and by every RTL file that needs a width or a
// region base. Holds macros only.

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// ************************************************************************
// Data path
// ************************************************************************

`define LSU_DATA_W        32            // Register and memory word width
`define LSU_OFFSET_W      12            // Immediate offset from decode

// ************************************************************************
// Region map
// ************************************************************************

// 64 KB DCCM
`define LSU_DCCM_SADR     32'hF004_0000
`define LSU_DCCM_ADDR_W   16            // Byte address bits inside the DCCM

// 32 KB of PIC memory-mapped registers
`define LSU_PIC_SADR      32'hF00C_0000
`define LSU_PIC_ADDR_W    15            // Byte address bits inside the PIC

// Anything outside both windows is external. There is no bus port,
// so external accesses end as access faults.

`endif

// ==== design/lsu_pkg.sv ====
// Types shared by the load/store unit stages.
// Each stage register carries its own packed bundle. The modules import
// this package by wildcard in their headers.

`include "lsu_params.svh"

package lsu_pkg;

   // Access size as decoded from funct3
   typedef enum logic [1:0] {
      sz_byte = 2'b00,
      sz_half = 2'b01,
      sz_word = 2'b10
   } lsu_size_e;

   // Target of an access after address decode
   typedef enum logic [1:0] {
      rgn_ext  = 2'b00,
      rgn_dccm = 2'b01,
      rgn_pic  = 2'b10
   } lsu_region_e;

   // Exception cause reported in dc3
   typedef enum logic [0:0] {
      exc_misaligned   = 1'b0,
      exc_access_fault = 1'b1
   } lsu_exc_e;

   // Control packet from decode
   typedef struct packed {
      logic      valid;
      logic      load;
      logic      store;
      lsu_size_e size;
      logic      unsign;                        // Zero extend on load
   } lsu_pkt_t;

   // Request as held in dc2
   typedef struct packed {
      lsu_pkt_t                 pkt;
      logic [31:0]              addr;
      logic [`LSU_DATA_W-1:0]   store_data;
      lsu_region_e              region;
      logic                     fault;          // Access will not be performed
      lsu_exc_e                 fault_type;
   } lsu_req_t;

   // Response bundle as held in dc3. Low address bits give the load lanes
   typedef struct packed {
      lsu_pkt_t    pkt;
      logic [31:0] addr;
      lsu_region_e region;
      logic        fault;
      lsu_exc_e    fault_type;
   } lsu_rsp_t;

   // Precise exception reported to the trap logic
   typedef struct packed {
      logic        exc_valid;
      logic        is_store;
      lsu_exc_e    exc_type;
      logic [31:0] addr;                        // Faulting effective address
   } lsu_error_pkt_t;

endpackage

// ==== design/lsu_addr_gen.sv ====
// Address generation stage of the load/store unit.
// Forms the effective address from rs1 and the immediate, decodes the
// target region, checks alignment and size rules, and registers the
// whole request into dc2. A new request can be taken every cycle.

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_addr_gen import lsu_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_l,
   input  lsu_pkt_t                 lsu_p,        // Control packet from decode
   input  logic [`LSU_DATA_W-1:0]   rs1,          // Base address operand
   input  logic [`LSU_OFFSET_W-1:0] offset,       // Signed immediate
   input  logic [`LSU_DATA_W-1:0]   store_data,   // rs2 for stores
   output lsu_req_t                 req_dc2
);

   localparam int ow = `LSU_OFFSET_W;
   localparam int dccm_aw = `LSU_DCCM_ADDR_W;
   localparam int pic_aw = `LSU_PIC_ADDR_W;
   localparam logic [31:0] dccm_base = `LSU_DCCM_SADR;
   localparam logic [31:0] pic_base = `LSU_PIC_SADR;

   logic                   cout;
   logic                   sign;
   logic [ow-1:0]          addr_lo;
   logic [31:ow]           addr_hi;
   logic [31:ow]           rs1_inc;
   logic [31:ow]           rs1_dec;
   logic [31:0]            addr_dc1;
   lsu_region_e            region_dc1;
   logic                   access_dc1;
   logic                   misaligned_dc1;
   logic                   acc_fault_dc1;

   // Registered dc2 fields
   lsu_pkt_t               pkt_q;
   logic                   fault_q;
   lsu_exc_e               fault_type_q;
   logic [31:0]            addr_q;
   logic [`LSU_DATA_W-1:0] data_q;
   lsu_region_e            region_q;

   // ************************************************************************
   // Effective address
   // ************************************************************************

   // Only the low 12 bits go through an adder
   assign {cout, addr_lo} = {1'b0, rs1[ow-1:0]} + {1'b0, offset};
   assign sign = offset[ow-1];

   assign rs1_inc = rs1[31:ow] + 1'b1;
   assign rs1_dec = rs1[31:ow] - 1'b1;

   // Upper part picked by offset sign and the low carry
   always_comb begin
      case ({sign, cout})
         2'b01:   addr_hi = rs1_inc;    // Positive offset carried out
         2'b10:   addr_hi = rs1_dec;    // Negative offset with no carry
         default: addr_hi = rs1[31:ow];
      endcase
   end

   assign addr_dc1 = {addr_hi, addr_lo};

   // ************************************************************************
   // Region decode and fault checks
   // ************************************************************************

   always_comb begin
      if (addr_dc1[31:dccm_aw] == dccm_base[31:dccm_aw])
         region_dc1 = rgn_dccm;
      else if (addr_dc1[31:pic_aw] == pic_base[31:pic_aw])
         region_dc1 = rgn_pic;
      else
         region_dc1 = rgn_ext;
   end

   assign access_dc1 = lsu_p.valid & (lsu_p.load | lsu_p.store);

   assign misaligned_dc1 = ((lsu_p.size == sz_half) & addr_dc1[0]) |
                           ((lsu_p.size == sz_word) & (|addr_dc1[1:0]));

   // No bus behind external space; PIC registers take words only
   assign acc_fault_dc1 = (region_dc1 == rgn_ext) |
                          ((region_dc1 == rgn_pic) & (lsu_p.size != sz_word));

   // ************************************************************************
   // dc2 register
   // ************************************************************************

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         pkt_q        <= '0;
         fault_q      <= 1'b0;
         fault_type_q <= exc_misaligned;
      end else begin
         pkt_q        <= lsu_p;
         fault_q      <= access_dc1 & (misaligned_dc1 | acc_fault_dc1);
         // Misalignment wins when both apply
         fault_type_q <= misaligned_dc1 ? exc_misaligned : exc_access_fault;
      end
   end

   always_ff @(posedge clk) begin
      addr_q   <= addr_dc1;
      data_q   <= store_data;
      region_q <= region_dc1;
   end

   assign req_dc2 = '{pkt:        pkt_q,
                      addr:       addr_q,
                      store_data: data_q,
                      region:     region_q,
                      fault:      fault_q,
                      fault_type: fault_type_q};

endmodule

// ==== design/lsu_dccm_ctl.sv ====
// Memory access stage of the load/store unit.
// Drives the DCCM or PIC strobes for the request in dc2, places store
// data on the byte lanes, and registers the response bundle into dc3.
// The dc2 flush is applied here and nowhere else.

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_dccm_ctl import lsu_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_l,
   input  lsu_req_t                    req_dc2,
   input  logic                        flush_dc2,        // Kill whatever is in dc2

   // DCCM port
   output logic                        dccm_rden,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_addr,        // Word aligned offset
   output logic [`LSU_DATA_W-1:0]      dccm_wr_data,
   output logic [`LSU_DATA_W/8-1:0]    dccm_wr_byteen,

   // PIC port
   output logic                        picm_rden,
   output logic                        picm_wren,
   output logic [31:0]                 picm_addr,
   output logic [`LSU_DATA_W-1:0]      picm_wr_data,

   output lsu_rsp_t                    rsp_dc3
);

   localparam int dccm_aw = `LSU_DCCM_ADDR_W;

   logic                         access_dc2;
   logic                         go_dc2;            // Access really happens
   logic                         to_dccm;
   logic                         to_pic;
   logic [1:0]                   lane;
   logic [`LSU_DATA_W/8-1:0]     byteen;
   logic [`LSU_DATA_W-1:0]       lane_data;

   // Registered dc3 fields
   lsu_pkt_t                     pkt_q;
   logic                         fault_q;
   lsu_exc_e                     fault_type_q;
   logic [31:0]                  addr_q;
   lsu_region_e                  region_q;

   // ************************************************************************
   // Strobes
   // ************************************************************************

   assign access_dc2 = req_dc2.pkt.valid & (req_dc2.pkt.load | req_dc2.pkt.store);
   assign go_dc2     = access_dc2 & ~flush_dc2 & ~req_dc2.fault;

   assign to_dccm = go_dc2 & (req_dc2.region == rgn_dccm);
   assign to_pic  = go_dc2 & (req_dc2.region == rgn_pic);

   // At most one of these is high
   assign dccm_rden = to_dccm & req_dc2.pkt.load;
   assign dccm_wren = to_dccm & req_dc2.pkt.store;
   assign picm_rden = to_pic & req_dc2.pkt.load;
   assign picm_wren = to_pic & req_dc2.pkt.store;

   assign dccm_addr = {req_dc2.addr[dccm_aw-1:2], 2'b00};
   assign picm_addr = req_dc2.addr;        // PIC sees the full address

   // ************************************************************************
   // Store lane placement
   // ************************************************************************

   assign lane = req_dc2.addr[1:0];

   always_comb begin
      case (req_dc2.pkt.size)
         sz_byte: byteen = 4'b0001 << lane;
         sz_half: byteen = 4'b0011 << lane;
         default: byteen = 4'b1111;
      endcase
   end

   // Shift the low bytes up to the addressed lane
   assign lane_data = req_dc2.store_data << {lane, 3'b000};

   assign dccm_wr_data   = lane_data;
   assign dccm_wr_byteen = byteen;
   assign picm_wr_data   = lane_data;   // Always a full word

   // ************************************************************************
   // dc3 register
   // ************************************************************************

   // Fault fields survive a flush so the PMU still sees misalignment
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         pkt_q        <= '0;
         fault_q      <= 1'b0;
         fault_type_q <= exc_misaligned;
      end else begin
         pkt_q        <= req_dc2.pkt;
         pkt_q.valid  <= req_dc2.pkt.valid & ~flush_dc2;
         fault_q      <= req_dc2.fault;
         fault_type_q <= req_dc2.fault_type;
      end
   end

   always_ff @(posedge clk) begin
      addr_q   <= req_dc2.addr;
      region_q <= req_dc2.region;
   end

   assign rsp_dc3 = '{pkt:        pkt_q,
                      addr:       addr_q,
                      region:     region_q,
                      fault:      fault_q,
                      fault_type: fault_type_q};

endmodule

// ==== design/lsu_load_align.sv ====
// Result stage of the load/store unit.
// Picks the read word from DCCM or PIC, moves the addressed bytes down
// and extends them to a full word. Also forms the precise exception
// packet and the PMU misaligned strobe for the access in dc3.

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_load_align import lsu_pkg::*; (
   input  lsu_rsp_t                 rsp_dc3,
   input  logic [`LSU_DATA_W-1:0]   dccm_rd_data,     // Read data, one cycle after rden
   input  logic [`LSU_DATA_W-1:0]   picm_rd_data,
   output logic                     lsu_load_valid_dc3,
   output logic [`LSU_DATA_W-1:0]   lsu_result_dc3,
   output lsu_error_pkt_t           lsu_error_pkt_dc3,
   output logic                     lsu_pmu_misaligned_dc3
);

   localparam int dw = `LSU_DATA_W;

   logic [dw-1:0] rd_word;
   logic [dw-1:0] rd_shift;
   logic          byte_sign;
   logic          half_sign;

   // ************************************************************************
   // Load data
   // ************************************************************************

   assign rd_word = (rsp_dc3.region == rgn_pic) ? picm_rd_data : dccm_rd_data;

   // Bring the addressed byte down to lane 0
   assign rd_shift = rd_word >> {rsp_dc3.addr[1:0], 3'b000};

   assign byte_sign = ~rsp_dc3.pkt.unsign & rd_shift[7];
   assign half_sign = ~rsp_dc3.pkt.unsign & rd_shift[15];

   always_comb begin
      case (rsp_dc3.pkt.size)
         sz_byte: lsu_result_dc3 = {{(dw-8){byte_sign}}, rd_shift[7:0]};
         sz_half: lsu_result_dc3 = {{(dw-16){half_sign}}, rd_shift[15:0]};
         default: lsu_result_dc3 = rd_shift;
      endcase
   end

   // Faulted loads return an exception and no result
   assign lsu_load_valid_dc3 = rsp_dc3.pkt.valid & rsp_dc3.pkt.load & ~rsp_dc3.fault;

   // ************************************************************************
   // Exception and PMU
   // ************************************************************************

   always_comb begin
      lsu_error_pkt_dc3.exc_valid = rsp_dc3.pkt.valid & rsp_dc3.fault;
      lsu_error_pkt_dc3.is_store  = rsp_dc3.pkt.store;
      lsu_error_pkt_dc3.exc_type  = rsp_dc3.fault_type;
      lsu_error_pkt_dc3.addr      = rsp_dc3.addr;
   end

   // Counted even for flushed accesses, so no valid term here
   assign lsu_pmu_misaligned_dc3 = rsp_dc3.fault & (rsp_dc3.fault_type == exc_misaligned);

endmodule

// ==== design/lsu_top.sv ====
// Load/store unit top level.
// Three stages: address generation (dc1 to dc2), memory access
// (dc2 to dc3) and load alignment with exception reporting in dc3.
// DCCM and PIC memories sit outside and answer reads one cycle late.

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_l,

   // Request from decode
   input  lsu_pkt_t                    lsu_p,
   input  logic [`LSU_DATA_W-1:0]      rs1,
   input  logic [`LSU_OFFSET_W-1:0]    offset,
   input  logic [`LSU_DATA_W-1:0]      store_data,
   input  logic                        flush_dc2,

   // DCCM
   output logic                        dccm_rden,
   output logic                        dccm_wren,
   output logic [`LSU_DCCM_ADDR_W-1:0] dccm_addr,
   output logic [`LSU_DATA_W-1:0]      dccm_wr_data,
   output logic [`LSU_DATA_W/8-1:0]    dccm_wr_byteen,
   input  logic [`LSU_DATA_W-1:0]      dccm_rd_data,

   // PIC
   output logic                        picm_rden,
   output logic                        picm_wren,
   output logic [31:0]                 picm_addr,
   output logic [`LSU_DATA_W-1:0]      picm_wr_data,
   input  logic [`LSU_DATA_W-1:0]      picm_rd_data,

   // dc3 results
   output logic                        lsu_load_valid_dc3,
   output logic [`LSU_DATA_W-1:0]      lsu_result_dc3,
   output lsu_error_pkt_t              lsu_error_pkt_dc3,
   output logic                        lsu_pmu_misaligned_dc3
);

   lsu_req_t req_dc2;      // Request bundle in dc2
   lsu_rsp_t rsp_dc3;      // Response bundle in dc3

   lsu_addr_gen u_addr_gen (
      .clk        (clk),
      .rst_l      (rst_l),
      .lsu_p      (lsu_p),
      .rs1        (rs1),
      .offset     (offset),
      .store_data (store_data),
      .req_dc2    (req_dc2)
   );

   lsu_dccm_ctl u_dccm_ctl (
      .clk            (clk),
      .rst_l          (rst_l),
      .req_dc2        (req_dc2),
      .flush_dc2      (flush_dc2),
      .dccm_rden      (dccm_rden),
      .dccm_wren      (dccm_wren),
      .dccm_addr      (dccm_addr),
      .dccm_wr_data   (dccm_wr_data),
      .dccm_wr_byteen (dccm_wr_byteen),
      .picm_rden      (picm_rden),
      .picm_wren      (picm_wren),
      .picm_addr      (picm_addr),
      .picm_wr_data   (picm_wr_data),
      .rsp_dc3        (rsp_dc3)
   );

   lsu_load_align u_load_align (
      .rsp_dc3                (rsp_dc3),
      .dccm_rd_data           (dccm_rd_data),
      .picm_rd_data           (picm_rd_data),
      .lsu_load_valid_dc3     (lsu_load_valid_dc3),
      .lsu_result_dc3         (lsu_result_dc3),
      .lsu_error_pkt_dc3      (lsu_error_pkt_dc3),
      .lsu_pmu_misaligned_dc3 (lsu_pmu_misaligned_dc3)
   );

endmodule

// ==== verif/lsu_tb.sv ====
// Self-checking testbench for the load/store unit.
// Sends random loads and stores into lsu_top from a fixed seed, answers the
// DCCM and PIC ports from local memories, and compares strobes and dc3
// results with a reference model kept in this file.

`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();

   localparam int unsigned seed = 32'h54cd_8214;
   localparam int num_req = 2000;
   localparam int rst_cycles = 5;
   localparam int max_cycles = num_req + 100;      // Requests, reset, drain and margin
   localparam int dccm_aw = `LSU_DCCM_ADDR_W;
   localparam int pic_aw = `LSU_PIC_ADDR_W;
   localparam logic [31:0] dccm_base = `LSU_DCCM_SADR;
   localparam logic [31:0] pic_base = `LSU_PIC_SADR;

   // Model view of one request as it moves down the pipe
   typedef struct packed {
      logic        access;                        // Load or store presented
      logic        load;
      logic        store;
      lsu_size_e   size;
      logic        unsign;
      logic [31:0] rs1;
      logic [11:0] offset;
      logic [31:0] addr;
      logic [31:0] wdata;
      lsu_region_e region;
      logic        misal;
      logic        acc_fault;
      logic        flush;                         // Flush raised while in dc2
      logic [31:0] result;                        // Predicted load data
   } exp_t;

   logic           clk;
   logic           rst_l;
   lsu_pkt_t       lsu_p;
   logic [31:0]    rs1;
   logic [11:0]    offset;
   logic [31:0]    store_data;
   logic           flush_dc2;
   logic           dccm_rden;
   logic           dccm_wren;
   logic [15:0]    dccm_addr;
   logic [31:0]    dccm_wr_data;
   logic [3:0]     dccm_wr_byteen;
   logic [31:0]    dccm_rd_data;
   logic           picm_rden;
   logic           picm_wren;
   logic [31:0]    picm_addr;
   logic [31:0]    picm_wr_data;
   logic [31:0]    picm_rd_data;
   logic           lsu_load_valid_dc3;
   logic [31:0]    lsu_result_dc3;
   lsu_error_pkt_t lsu_error_pkt_dc3;
   logic           lsu_pmu_misaligned_dc3;

   logic [31:0] dccm_mem [0:(1 << (dccm_aw - 2)) - 1];   // Responder memories
   logic [31:0] pic_mem  [0:(1 << (pic_aw - 2)) - 1];
   logic [7:0]  mdl_dccm [0:(1 << dccm_aw) - 1];         // Model copies
   logic [31:0] mdl_pic  [0:(1 << (pic_aw - 2)) - 1];

   exp_t e1;
   exp_t e2;
   exp_t e3;
   int   errors = 0;
   int   n_loads = 0;
   int   n_exc = 0;
   int   n_flush = 0;
   int   cycle_cnt = 0;

   lsu_top u_dut (
      .clk                    (clk),
      .rst_l                  (rst_l),
      .lsu_p                  (lsu_p),
      .rs1                    (rs1),
      .offset                 (offset),
      .store_data             (store_data),
      .flush_dc2              (flush_dc2),
      .dccm_rden              (dccm_rden),
      .dccm_wren              (dccm_wren),
      .dccm_addr              (dccm_addr),
      .dccm_wr_data           (dccm_wr_data),
      .dccm_wr_byteen         (dccm_wr_byteen),
      .dccm_rd_data           (dccm_rd_data),
      .picm_rden              (picm_rden),
      .picm_wren              (picm_wren),
      .picm_addr              (picm_addr),
      .picm_wr_data           (picm_wr_data),
      .picm_rd_data           (picm_rd_data),
      .lsu_load_valid_dc3     (lsu_load_valid_dc3),
      .lsu_result_dc3         (lsu_result_dc3),
      .lsu_error_pkt_dc3      (lsu_error_pkt_dc3),
      .lsu_pmu_misaligned_dc3 (lsu_pmu_misaligned_dc3)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout: run did not complete within %0d cycles", max_cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // ************************************************************************
   // Memory responders answer rden with data one cycle later
   // ************************************************************************

   always @(posedge clk) begin : mem_responder
      logic [31:0] merged;
      if (dccm_rden)
         dccm_rd_data <= dccm_mem[dccm_addr[dccm_aw-1:2]];
      if (dccm_wren) begin
         merged = dccm_mem[dccm_addr[dccm_aw-1:2]];
         for (int b = 0; b < 4; b++)
            if (dccm_wr_byteen[b])
               merged[8*b +: 8] = dccm_wr_data[8*b +: 8];
         dccm_mem[dccm_addr[dccm_aw-1:2]] <= merged;
      end
      if (picm_rden)
         picm_rd_data <= pic_mem[picm_addr[pic_aw-1:2]];
      if (picm_wren)
         pic_mem[picm_addr[pic_aw-1:2]] <= picm_wr_data;
   end

   // Start contents depend on the full word index and a salt
   function automatic logic [31:0] fill_word(input logic [31:0] idx, input logic [31:0] salt);
      return (idx * 32'h9e37_79b9) ^ {idx[15:0], idx[31:16]} ^ salt;
   endfunction

   function automatic int size_bytes(input lsu_size_e s);
      case (s)
         sz_byte: return 1;
         sz_half: return 2;
         default: return 4;
      endcase
   endfunction

   task automatic init_memories();
      logic [31:0] w;
      for (int i = 0; i < (1 << (dccm_aw - 2)); i++) begin
         w = fill_word(i, 32'h3c5a_0f96);
         dccm_mem[i] = w;
         for (int b = 0; b < 4; b++)
            mdl_dccm[4*i + b] = w[8*b +: 8];
      end
      for (int i = 0; i < (1 << (pic_aw - 2)); i++) begin
         pic_mem[i] = fill_word(i, 32'hc3a5_f069);
         mdl_pic[i] = pic_mem[i];
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got, exp);
   endtask

   // ************************************************************************
   // Stimulus and reference model
   // ************************************************************************

   task automatic gen_request(output exp_t e);
      int unsigned pick;
      logic [31:0] target;
      e = '0;
      e.flush = ($urandom_range(0, 9) == 0);
      if ($urandom_range(0, 99) < 15)
         return;                                  // Idle cycle
      e.access = 1'b1;
      e.load   = $urandom_range(0, 1);
      e.store  = ~e.load;
      e.size   = lsu_size_e'($urandom_range(0, 2));
      e.unsign = $urandom_range(0, 1);
      e.wdata  = $urandom();
      pick = $urandom_range(0, 99);
      if (pick < 60)
         target = dccm_base + $urandom_range(0, 63);  // Small window so loads hit stores
      else if (pick < 75)
         target = pic_base + $urandom_range(0, 63);
      else if (pick < 88)
         target = $urandom();
      else
         target = dccm_base + $urandom_range(0, 16'hffff);
      // Most half and word accesses get forced aligned
      if ($urandom_range(0, 99) < 88) begin
         if (e.size == sz_half)
            target[0] = 1'b0;
         if (e.size == sz_word)
            target[1:0] = 2'b00;
      end
      e.offset = $urandom();
      e.rs1 = target - {{20{e.offset[11]}}, e.offset};
      // Model address and decode
      e.addr = e.rs1 + {{20{e.offset[11]}}, e.offset};
      if (e.addr[31:dccm_aw] == dccm_base[31:dccm_aw])
         e.region = rgn_dccm;
      else if (e.addr[31:pic_aw] == pic_base[31:pic_aw])
         e.region = rgn_pic;
      else
         e.region = rgn_ext;
      e.misal = (e.size == sz_half && e.addr[0]) || (e.size == sz_word && e.addr[1:0] != 0);
      e.acc_fault = (e.region == rgn_ext) || (e.region == rgn_pic && e.size != sz_word);
   endtask

   task automatic drive_request(input exp_t e);
      lsu_p.valid  = e.access;
      lsu_p.load   = e.load;
      lsu_p.store  = e.store;
      lsu_p.size   = e.size;
      lsu_p.unsign = e.unsign;
      rs1          = e.rs1;
      offset       = e.offset;
      store_data   = e.wdata;
   endtask

   // Checks the dc2 strobes and predicts load data from the model memory
   task automatic check_dc2();
      logic        go;
      logic [3:0]  exp_stb;
      logic [3:0]  exp_be;
      logic [31:0] exp_wd;
      logic [31:0] lane_mask;
      int          n;
      int          lane;
      go = e2.access && !e2.flush && !(e2.misal || e2.acc_fault);
      exp_stb = {go && e2.region == rgn_dccm && e2.load, go && e2.region == rgn_dccm && e2.store,
                 go && e2.region == rgn_pic && e2.load, go && e2.region == rgn_pic && e2.store};
      if ({dccm_rden, dccm_wren, picm_rden, picm_wren} !== exp_stb)
         report_mismatch("strobes {dccm_rden,dccm_wren,picm_rden,picm_wren}",
                         {dccm_rden, dccm_wren, picm_rden, picm_wren}, exp_stb);
      if (e2.access && e2.flush)
         n_flush++;
      n = size_bytes(e2.size);
      lane = e2.addr[1:0];
      if (go && e2.region == rgn_dccm) begin
         if (dccm_addr !== {e2.addr[dccm_aw-1:2], 2'b00})
            report_mismatch("dccm_addr", dccm_addr, {e2.addr[dccm_aw-1:2], 2'b00});
         exp_be = '0;
         exp_wd = '0;
         lane_mask = '0;
         e2.result = '0;
         for (int b = 0; b < n; b++) begin
            if (e2.store) begin
               exp_be[lane + b] = 1'b1;
               exp_wd[8*(lane + b) +: 8] = e2.wdata[8*b +: 8];
               lane_mask[8*(lane + b) +: 8] = 8'hff;
               mdl_dccm[e2.addr[dccm_aw-1:0] + b] = e2.wdata[8*b +: 8];
            end else
               e2.result[8*b +: 8] = mdl_dccm[e2.addr[dccm_aw-1:0] + b];
         end
         if (!e2.unsign && n == 1)
            e2.result[31:8] = {24{e2.result[7]}};
         if (!e2.unsign && n == 2)
            e2.result[31:16] = {16{e2.result[15]}};
         if (e2.store && dccm_wr_byteen !== exp_be)
            report_mismatch("dccm_wr_byteen", dccm_wr_byteen, exp_be);
         if (e2.store && (dccm_wr_data & lane_mask) !== exp_wd)
            report_mismatch("dccm_wr_data", dccm_wr_data & lane_mask, exp_wd);
      end
      if (go && e2.region == rgn_pic) begin
         if (picm_addr !== e2.addr)
            report_mismatch("picm_addr", picm_addr, e2.addr);
         if (e2.store && picm_wr_data !== e2.wdata)
            report_mismatch("picm_wr_data", picm_wr_data, e2.wdata);
         if (e2.store)
            mdl_pic[e2.addr[pic_aw-1:2]] = e2.wdata;
         else
            e2.result = mdl_pic[e2.addr[pic_aw-1:2]];
      end
   endtask

   task automatic check_dc3();
      logic     fault;
      logic     exp_lv;
      logic     exp_exc;
      lsu_exc_e exp_type;
      fault = e3.misal || e3.acc_fault;
      exp_lv = e3.access && e3.load && !e3.flush && !fault;
      exp_exc = e3.access && !e3.flush && fault;
      exp_type = e3.misal ? exc_misaligned : exc_access_fault;   // Misalignment first
      if (lsu_load_valid_dc3 !== exp_lv)
         report_mismatch("lsu_load_valid_dc3", lsu_load_valid_dc3, exp_lv);
      if (exp_lv)
         n_loads++;
      if (exp_lv && lsu_result_dc3 !== e3.result)
         report_mismatch("lsu_result_dc3", lsu_result_dc3, e3.result);
      if (lsu_error_pkt_dc3.exc_valid !== exp_exc)
         report_mismatch("lsu_error_pkt_dc3.exc_valid", lsu_error_pkt_dc3.exc_valid, exp_exc);
      if (exp_exc)
         n_exc++;
      if (exp_exc && lsu_error_pkt_dc3.exc_type !== exp_type)
         report_mismatch("lsu_error_pkt_dc3.exc_type", lsu_error_pkt_dc3.exc_type, exp_type);
      if (exp_exc && lsu_error_pkt_dc3.addr !== e3.addr)
         report_mismatch("lsu_error_pkt_dc3.addr", lsu_error_pkt_dc3.addr, e3.addr);
      if (exp_exc && lsu_error_pkt_dc3.is_store !== e3.store)
         report_mismatch("lsu_error_pkt_dc3.is_store", lsu_error_pkt_dc3.is_store, e3.store);
      if (lsu_pmu_misaligned_dc3 !== e3.misal)
         report_mismatch("lsu_pmu_misaligned_dc3", lsu_pmu_misaligned_dc3, e3.misal);
   endtask

   // ************************************************************************
   // Main sequence
   // ************************************************************************

   initial begin
      void'($urandom(seed));
      rst_l        = 1'b0;
      lsu_p        = '0;
      rs1          = '0;
      offset       = '0;
      store_data   = '0;
      flush_dc2    = 1'b0;
      dccm_rd_data = '0;
      picm_rd_data = '0;
      e1 = '0;
      e2 = '0;
      e3 = '0;
      init_memories();
      repeat (rst_cycles) @(negedge clk);
      if ({dccm_rden, dccm_wren, picm_rden, picm_wren, lsu_load_valid_dc3,
           lsu_error_pkt_dc3.exc_valid, lsu_pmu_misaligned_dc3} !== 7'b0)
         report_mismatch("strobes and dc3 valids in reset",
                         {dccm_rden, dccm_wren, picm_rden, picm_wren, lsu_load_valid_dc3,
                          lsu_error_pkt_dc3.exc_valid, lsu_pmu_misaligned_dc3}, 32'h0);
      rst_l = 1'b1;

      // Two extra cycles drain the pipe
      for (int i = 0; i < num_req + 2; i++) begin
         @(negedge clk);
         e3 = e2;
         e2 = e1;
         if (i < num_req)
            gen_request(e1);
         else
            e1 = '0;
         drive_request(e1);
         flush_dc2 = e2.flush;
         #1;
         check_dc2();
         check_dc3();
      end

      $display("Requests %0d, loads %0d, exceptions %0d, flushed %0d, errors %0d",
               num_req, n_loads, n_exc, n_flush, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu_addr_gen.sv
design/lsu_dccm_ctl.sv
design/lsu_load_align.sv
design/lsu_top.sv
verif/lsu_tb.sv
